/* tb.f */
common/fetch_pkg.sv
hw/imem.sv
fetch/static_predictor.sv
fetch/fetch_stage.sv
hw/branch_resolve.sv
hw/fetch_top.sv
tests/fetch_asserts.sv
tests/tb_checker.sv
tests/tb_top.sv

/* run.sh */
#!/bin/sh
# build and run the fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_top -f tb.f -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TB PASSED$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

/* tests/tb_top.sv */
module tb_top
    import fetch_pkg::*;
;

    localparam int ADDR_W      = 8;
    localparam int PROG_WORDS  = 2**ADDR_W;
    localparam int N_RETIRE    = 2000;
    localparam int CYC_PER_RET = 40;
    // load cycles, reset tail, then the retire budget
    localparam int LIMIT_CYC   = PROG_WORDS + 4 + N_RETIRE * CYC_PER_RET;

    logic               clk;
    logic               rst;
    logic               load_en;
    logic [ADDR_W-1:0]  load_addr;
    logic [INSTR_W-1:0] load_data;
    logic               ret_valid;
    logic [ADDR_W-1:0]  ret_pc;
    logic [INSTR_W-1:0] ret_instr;
    logic               ret_ready;
    logic [INSTR_W-1:0] word;
    integer             seed;
    int                 ret_count;
    int                 val_errors;
    int                 stab_errors;
    int                 total_errors;

    fetch_top #(
        .ADDR_W (ADDR_W)
    ) u_fetch_top (
        .i_clk       (clk),
        .i_rst       (rst),
        .i_load_en   (load_en),
        .i_load_addr (load_addr),
        .i_load_data (load_data),
        .o_ret_valid (ret_valid),
        .o_ret_pc    (ret_pc),
        .o_ret_instr (ret_instr),
        .i_ret_ready (ret_ready)
    );

    tb_checker #(
        .ADDR_W (ADDR_W)
    ) u_tb_checker (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_load_en     (load_en),
        .i_load_addr   (load_addr),
        .i_load_data   (load_data),
        .i_ret_valid   (ret_valid),
        .i_ret_pc      (ret_pc),
        .i_ret_instr   (ret_instr),
        .i_ret_ready   (ret_ready),
        .o_ret_count   (ret_count),
        .o_val_errors  (val_errors),
        .o_stab_errors (stab_errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        seed      = 32'h24e7_0d66;
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        ret_ready = 1'b0;
        // program goes in while reset holds fetch idle
        for (int i = 0; i < PROG_WORDS; i++) begin
            @(negedge clk);
            word = $random(seed);
            // roughly one word in three becomes control flow
            if ((($random(seed) & 32'h7fff) % 3) == 0) begin
                word[OPC_LSB +: OPC_W] = ($random(seed) & 1) ? OPC_JUMP : OPC_BRANCH;
            end
            load_en   = 1'b1;
            load_addr = ADDR_W'(i);
            load_data = word;
        end
        @(negedge clk);
        load_en = 1'b0;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        while (ret_count < N_RETIRE) begin
            ret_ready = ($random(seed) & 3) != 0;
            @(negedge clk);
        end
        total_errors = val_errors + stab_errors +
                       u_fetch_top.u_fetch_stage.u_fetch_asserts.fail_count;
        $display("retired %0d, value errors %0d, stability errors %0d, assertion errors %0d",
                 ret_count, val_errors, stab_errors,
                 u_fetch_top.u_fetch_stage.u_fetch_asserts.fail_count);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (LIMIT_CYC) @(posedge clk);
        $display("timeout: only %0d of %0d instructions retired in time",
                 ret_count, N_RETIRE);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* tests/tb_checker.sv */
module tb_checker
    import fetch_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_load_en,
    input  logic [ADDR_W-1:0]  i_load_addr,
    input  logic [INSTR_W-1:0] i_load_data,
    input  logic               i_ret_valid,
    input  logic [ADDR_W-1:0]  i_ret_pc,
    input  logic [INSTR_W-1:0] i_ret_instr,
    input  logic               i_ret_ready,
    output int                 o_ret_count,
    output int                 o_val_errors,
    output int                 o_stab_errors
);

    logic [INSTR_W-1:0] prog [2**ADDR_W];
    logic [ADDR_W-1:0]  model_pc;
    logic               held;
    logic [ADDR_W-1:0]  held_pc;
    logic [INSTR_W-1:0] held_instr;
    int                 ret_count = 0;
    int                 val_errors = 0;
    int                 stab_errors = 0;

    assign o_ret_count   = ret_count;
    assign o_val_errors  = val_errors;
    assign o_stab_errors = stab_errors;

    // architectural next pc of a word, wraps with the pc width
    function automatic logic [ADDR_W-1:0] next_pc(input logic [INSTR_W-1:0] w,
                                                   input logic [ADDR_W-1:0]  pc);
        logic [OPC_W-1:0]  opc;
        logic [COND_W-1:0] cond;
        logic              taken;
        opc   = w[OPC_LSB +: OPC_W];
        cond  = w[COND_LSB +: COND_W];
        taken = (opc == OPC_JUMP) || ((opc == OPC_BRANCH) && (cond == '0 || cond[0]));
        return taken ? w[INSTR_W-1 -: ADDR_W] : pc + ADDR_W'(1);
    endfunction

    always @(posedge i_clk) begin
        if (i_load_en) begin
            prog[i_load_addr] = i_load_data;
        end
        if (i_rst) begin
            model_pc = '0;
            held     = 1'b0;
            if (i_ret_valid === 1'b1) begin
                val_errors++;
                $display("error reset_valid: expected 0 actual %0d", i_ret_valid);
            end
        end else begin
            // a stalled retire word must come back unchanged
            if (held && (i_ret_valid !== 1'b1 || i_ret_pc !== held_pc ||
                         i_ret_instr !== held_instr)) begin
                stab_errors++;
                $display("error ret_stable: expected %0d/%h/%h actual %0d/%h/%h",
                         1, held_pc, held_instr, i_ret_valid, i_ret_pc, i_ret_instr);
            end
            if (i_ret_valid && i_ret_ready) begin
                if (i_ret_pc !== model_pc) begin
                    val_errors++;
                    $display("error retire_pc: expected %h actual %h", model_pc, i_ret_pc);
                end
                if (i_ret_instr !== prog[model_pc]) begin
                    val_errors++;
                    $display("error retire_instr: expected %h actual %h",
                             prog[model_pc], i_ret_instr);
                end
                model_pc = next_pc(prog[model_pc], model_pc);
                ret_count++;
            end
            held       = i_ret_valid && !i_ret_ready;
            held_pc    = i_ret_pc;
            held_instr = i_ret_instr;
        end
    end

endmodule

/* tests/fetch_asserts.sv */
module fetch_asserts
    import fetch_pkg::*;
(
    input logic               i_clk,
    input logic               i_rst,
    input logic               i_mem_submit,
    input logic               i_mem_ack,
    input logic               i_valid,
    input logic               i_ready,
    input logic               i_flush,
    input logic [INSTR_W-1:0] i_instr
);

    int unsigned fail_count = 0;

    // ack answers the submit of the cycle before
    ack_after_submit: assert property (@(posedge i_clk) disable iff (i_rst)
        i_mem_ack |-> $past(i_mem_submit))
    else begin
        fail_count++;
        $error("memory ack without a submit in the previous cycle");
    end

    stall_holds_word: assert property (@(posedge i_clk) disable iff (i_rst)
        (i_valid && !i_ready) |=> (i_valid && $stable(i_instr)))
    else begin
        fail_count++;
        $error("fetch output changed or dropped while stalled");
    end

    quiet_after_reset: assert property (@(posedge i_clk)
        i_rst |=> (!i_valid && !i_flush))
    else begin
        fail_count++;
        $error("valid or flush high in the cycle after reset");
    end

endmodule

bind fetch_stage fetch_asserts u_fetch_asserts (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_mem_submit (o_mem_submit),
    .i_mem_ack    (i_mem_ack),
    .i_valid      (o_valid),
    .i_ready      (i_ready),
    .i_flush      (i_flush),
    .i_instr      (o_instr)
);

/* hw/fetch_top.sv */
module fetch_top
    import fetch_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_load_en,
    input  logic [ADDR_W-1:0]  i_load_addr,
    input  logic [INSTR_W-1:0] i_load_data,
    output logic               o_ret_valid,
    output logic [ADDR_W-1:0]  o_ret_pc,
    output logic [INSTR_W-1:0] o_ret_instr,
    input  logic               i_ret_ready
);

    logic               mem_submit;
    logic [ADDR_W-1:0]  mem_addr;
    logic               mem_ack;
    logic [INSTR_W-1:0] mem_data;
    logic               fe_valid;
    logic               fe_ready;
    logic [INSTR_W-1:0] fe_instr;
    logic [ADDR_W-1:0]  fe_pc;
    logic               fe_pred_taken;
    logic               flush;
    logic [ADDR_W-1:0]  flush_pc;

    imem #(
        .ADDR_W (ADDR_W)
    ) u_imem (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_load_en    (i_load_en),
        .i_load_addr  (i_load_addr),
        .i_load_data  (i_load_data),
        .i_mem_submit (mem_submit),
        .i_mem_addr   (mem_addr),
        .o_mem_ack    (mem_ack),
        .o_mem_data   (mem_data)
    );

    fetch_stage #(
        .ADDR_W (ADDR_W)
    ) u_fetch_stage (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .o_mem_submit (mem_submit),
        .o_mem_addr   (mem_addr),
        .i_mem_ack    (mem_ack),
        .i_mem_data   (mem_data),
        .o_valid      (fe_valid),
        .i_ready      (fe_ready),
        .o_instr      (fe_instr),
        .o_pc         (fe_pc),
        .o_pred_taken (fe_pred_taken),
        .i_flush      (flush),
        .i_flush_pc   (flush_pc)
    );

    branch_resolve #(
        .ADDR_W (ADDR_W)
    ) u_branch_resolve (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_valid      (fe_valid),
        .o_ready      (fe_ready),
        .i_instr      (fe_instr),
        .i_pc         (fe_pc),
        .i_pred_taken (fe_pred_taken),
        .o_flush      (flush),
        .o_flush_pc   (flush_pc),
        .o_ret_valid  (o_ret_valid),
        .o_ret_pc     (o_ret_pc),
        .o_ret_instr  (o_ret_instr),
        .i_ret_ready  (i_ret_ready)
    );

endmodule

/* hw/branch_resolve.sv */
module branch_resolve
    import fetch_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_valid,
    output logic               o_ready,
    input  logic [INSTR_W-1:0] i_instr,
    input  logic [ADDR_W-1:0]  i_pc,
    input  logic               i_pred_taken,
    output logic               o_flush,
    output logic [ADDR_W-1:0]  o_flush_pc,
    output logic               o_ret_valid,
    output logic [ADDR_W-1:0]  o_ret_pc,
    output logic [INSTR_W-1:0] o_ret_instr,
    input  logic               i_ret_ready
);

    logic [OPC_W-1:0]  opc;
    logic [COND_W-1:0] cond;
    logic [ADDR_W-1:0] target;
    logic              real_taken;
    logic              accept;
    logic              drop_q;

    assign opc    = i_instr[OPC_LSB +: OPC_W];
    assign cond   = i_instr[COND_LSB +: COND_W];
    assign target = i_instr[INSTR_W-1 -: ADDR_W];

    // outcome is fixed by the encoding, cond bit 0 for conditional ones
    assign real_taken = (opc == OPC_JUMP) ||
                        ((opc == OPC_BRANCH) && ((cond == '0) || cond[0]));

    assign o_ready    = !o_ret_valid || i_ret_ready;
    assign accept     = i_valid && o_ready && !drop_q;
    assign o_flush    = accept && (i_pred_taken != real_taken);
    assign o_flush_pc = real_taken ? target : i_pc + ADDR_W'(1);

    // a word behind our own flush never retires
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            drop_q <= 1'b0;
        end else begin
            drop_q <= o_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_ret_valid <= 1'b0;
        end else if (accept) begin
            o_ret_valid <= 1'b1;
        end else if (i_ret_ready) begin
            o_ret_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            o_ret_pc    <= i_pc;
            o_ret_instr <= i_instr;
        end
    end

endmodule

/* fetch/fetch_stage.sv */
module fetch_stage
    import fetch_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic               i_clk,
    input  logic               i_rst,
    output logic               o_mem_submit,
    output logic [ADDR_W-1:0]  o_mem_addr,
    input  logic               i_mem_ack,
    input  logic [INSTR_W-1:0] i_mem_data,
    output logic               o_valid,
    input  logic               i_ready,
    output logic [INSTR_W-1:0] o_instr,
    output logic [ADDR_W-1:0]  o_pc,
    output logic               o_pred_taken,
    input  logic               i_flush,
    input  logic [ADDR_W-1:0]  i_flush_pc
);

    logic               reset_ovr;
    logic [ADDR_W-1:0]  req_pc;
    logic               buf_valid;
    logic [INSTR_W-1:0] buf_instr;
    logic               tok_valid;
    logic [INSTR_W-1:0] tok_instr;
    logic               out_free;
    logic               out_load;
    logic               pred_taken;
    logic [ADDR_W-1:0]  pred_target;
    logic [ADDR_W-1:0]  pred_pc;

    // word of the current request, just returned or held back
    assign tok_valid = buf_valid || i_mem_ack;
    assign tok_instr = buf_valid ? buf_instr : i_mem_data;
    assign out_free  = !o_valid || i_ready;
    assign out_load  = tok_valid && out_free && !i_flush;

    static_predictor #(
        .ADDR_W (ADDR_W)
    ) u_static_predictor (
        .i_instr  (tok_instr),
        .i_pc     (req_pc),
        .i_block  (reset_ovr),
        .o_taken  (pred_taken),
        .o_target (pred_target)
    );

    assign pred_pc = pred_taken ? pred_target : req_pc + ADDR_W'(1);

    // next request once the word moves on or is flushed
    assign o_mem_submit = !i_rst && (reset_ovr || (tok_valid && (out_free || i_flush)));

    always_comb begin
        if (reset_ovr) begin
            o_mem_addr = '0;
        end else if (i_flush) begin
            o_mem_addr = i_flush_pc;
        end else begin
            o_mem_addr = pred_pc;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            reset_ovr <= 1'b1;
        end else if (o_mem_submit) begin
            reset_ovr <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_mem_submit) begin
            req_pc <= o_mem_addr;
        end
    end

    // one-entry skid buffer
    always_ff @(posedge i_clk) begin
        if (i_rst || i_flush) begin
            buf_valid <= 1'b0;
        end else if (i_mem_ack && !out_free) begin
            buf_valid <= 1'b1;
        end else if (out_free) begin
            buf_valid <= 1'b0;
        end
        if (i_mem_ack && !out_free && !i_flush) begin
            buf_instr <= i_mem_data;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else if (out_load) begin
            o_valid <= 1'b1;
        end else if (i_ready) begin
            o_valid <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (out_load) begin
            o_instr      <= tok_instr;
            o_pc         <= req_pc;
            o_pred_taken <= pred_taken;
        end
    end

endmodule

/* fetch/static_predictor.sv */
module static_predictor
    import fetch_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic [INSTR_W-1:0] i_instr,
    input  logic [ADDR_W-1:0]  i_pc,
    input  logic               i_block,
    output logic               o_taken,
    output logic [ADDR_W-1:0]  o_target
);

    logic [OPC_W-1:0]  opc;
    logic [COND_W-1:0] cond;

    assign opc      = i_instr[OPC_LSB +: OPC_W];
    assign cond     = i_instr[COND_LSB +: COND_W];
    assign o_target = i_instr[INSTR_W-1 -: ADDR_W];

    always_comb begin
        o_taken = 1'b0;
        if (!i_block) begin
            if (opc == OPC_JUMP) begin
                o_taken = 1'b1;
            end else if (opc == OPC_BRANCH) begin
                // backward conditional taken, forward not taken
                o_taken = (cond == '0) || (o_target < i_pc);
            end
        end
    end

endmodule

/* hw/imem.sv */
module imem
    import fetch_pkg::*;
#(
    parameter int ADDR_W = 8
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  logic               i_load_en,
    input  logic [ADDR_W-1:0]  i_load_addr,
    input  logic [INSTR_W-1:0] i_load_data,
    input  logic               i_mem_submit,
    input  logic [ADDR_W-1:0]  i_mem_addr,
    output logic               o_mem_ack,
    output logic [INSTR_W-1:0] o_mem_data
);

    logic [INSTR_W-1:0] mem [2**ADDR_W];

    // load port write and pipelined read share one clock
    always_ff @(posedge i_clk) begin
        if (i_load_en) begin
            mem[i_load_addr] <= i_load_data;
        end
        if (i_mem_submit) begin
            o_mem_data <= mem[i_mem_addr];
        end
    end

    // ack one cycle after each submit
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_mem_ack <= 1'b0;
        end else begin
            o_mem_ack <= i_mem_submit;
        end
    end

endmodule

/* common/fetch_pkg.sv */
package fetch_pkg;

    // instruction word
    localparam int INSTR_W = 32;

    // opcode field, bits 6..0
    localparam int OPC_LSB = 0;
    localparam int OPC_W   = 7;

    // condition field, bits 10..7
    // zero here means the branch is unconditional
    localparam int COND_LSB = 7;
    localparam int COND_W   = 4;

    // control flow opcodes
    localparam logic [OPC_W-1:0] OPC_BRANCH = 7'h0e;
    localparam logic [OPC_W-1:0] OPC_JUMP   = 7'h0f;

    // branch target lives in the top address bits of the word,
    // its width follows the PC width of the instance

endpackage
